//--- logic/lz_job_pkg.sv
// package: job PE widths, typedefs, packed structs and controller states
`default_nettype none

package lz_job_pkg;

  localparam int JOB_LEN          = 16;
  localparam int ISSUE_WIDTH      = 4;
  localparam int LAZY_LEN         = 3;
  localparam int META_HISTORY_LEN = 8;
  localparam int MIN_MATCH        = 3;

  typedef logic [15:0] addr_t;
  typedef logic [15:0] offset_t;
  typedef logic [2:0]  meta_len_t;
  typedef logic [7:0]  match_len_t;
  typedef logic [3:0]  pos_t;
  typedef logic [4:0]  ll_t;

  // one load beat from the hash engine
  typedef struct packed {
    addr_t                        head_addr;
    logic [ISSUE_WIDTH-1:0]       valid;
    addr_t [ISSUE_WIDTH-1:0]      history_addr;
    meta_len_t [ISSUE_WIDTH-1:0]  meta_len;
    logic [ISSUE_WIDTH-1:0]       can_ext;
    logic                         delim;
  } hash_beat_t;

  // history_addr already carries the meta history bias
  typedef struct packed {
    logic      valid;
    logic      can_ext;
    addr_t     history_addr;
    meta_len_t meta_len;
    offset_t   offset;
  } job_entry_t;

  typedef struct packed {
    addr_t [LAZY_LEN-1:0] head_addr;
    addr_t [LAZY_LEN-1:0] history_addr;
    logic [LAZY_LEN-1:0]  strb;
  } match_req_t;

  typedef struct packed {
    ll_t        ll;
    match_len_t ml;
    offset_t    offset;
    logic       eoj;
    match_len_t overlap_len;
    logic       delim;
  } seq_t;

  typedef enum logic [2:0] {
    LOAD,
    SEEK,
    MATCH_REQ,
    MATCH_RESP,
    SUMMARY,
    LIT_TAIL
  } job_state_e;

endpackage

`default_nettype wire

//--- logic/job_table.sv
// job entry table module, filled from hash engine load beats
`timescale 1ns/1ps
`default_nettype none

module job_table #(
  parameter int JOB_LEN     = lz_job_pkg::JOB_LEN,
  parameter int ISSUE_WIDTH = lz_job_pkg::ISSUE_WIDTH
) (
  input  wire                                       clk,
  input  wire                                       i_load,
  input  wire [1:0]                                 i_beat_idx,
  input  wire lz_job_pkg::hash_beat_t               i_beat,
  output lz_job_pkg::job_entry_t [JOB_LEN-1:0]      o_entries,
  output lz_job_pkg::addr_t                         o_head_addr,
  output logic                                      o_delim
);

  import lz_job_pkg::*;

  localparam int NUM_BEATS = JOB_LEN / ISSUE_WIDTH;

  job_entry_t [ISSUE_WIDTH-1:0] beat_entry;
  pos_t [ISSUE_WIDTH-1:0]       beat_pos;
  addr_t                        head_addr;

  // beat 0 brings its own head, later beats use the latched one
  assign head_addr = (i_beat_idx == 2'd0) ? i_beat.head_addr : o_head_addr;

  for (genvar j = 0; j < ISSUE_WIDTH; j++) begin : g_lane
    assign beat_pos[j] = pos_t'(i_beat_idx) * pos_t'(ISSUE_WIDTH) + pos_t'(j);

    assign beat_entry[j].valid        = i_beat.valid[j];
    assign beat_entry[j].can_ext      = i_beat.can_ext[j];
    assign beat_entry[j].meta_len     = i_beat.meta_len[j];
    assign beat_entry[j].history_addr = i_beat.history_addr[j] + addr_t'(META_HISTORY_LEN);
    // distance back from this position, on the raw history address
    assign beat_entry[j].offset =
        offset_t'(head_addr + addr_t'(beat_pos[j]) - i_beat.history_addr[j]);
  end

  always_ff @(posedge clk) begin
    if (i_load) begin
      if (i_beat_idx == 2'd0) begin
        o_head_addr <= i_beat.head_addr;
      end
      if (i_beat_idx == 2'(NUM_BEATS - 1)) begin
        o_delim <= i_beat.delim;
      end
      for (int j = 0; j < ISSUE_WIDTH; j++) begin
        o_entries[beat_pos[j]] <= beat_entry[j];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/lazy_window.sv
// lazy window module: candidate capture, grouped match request, length accumulation
`timescale 1ns/1ps
`default_nettype none

module lazy_window #(
  parameter int JOB_LEN  = lz_job_pkg::JOB_LEN,
  parameter int LAZY_LEN = lz_job_pkg::LAZY_LEN
) (
  input  wire                                        clk,
  input  wire                                        i_capture,
  input  wire lz_job_pkg::pos_t                      i_match_head,
  input  wire lz_job_pkg::job_entry_t [JOB_LEN-1:0]  i_entries,
  input  wire lz_job_pkg::addr_t                     i_head_addr,
  input  wire                                        i_resp_fire,
  input  wire lz_job_pkg::match_len_t [LAZY_LEN-1:0] i_resp_len,
  output lz_job_pkg::match_req_t                     o_req,
  output logic [LAZY_LEN-1:0]                        o_slot_valid,
  output lz_job_pkg::match_len_t [LAZY_LEN-1:0]      o_slot_len,
  output lz_job_pkg::offset_t [LAZY_LEN-1:0]         o_slot_offset
);

  import lz_job_pkg::*;

  logic [LAZY_LEN-1:0][4:0]  slot_pos;
  logic [LAZY_LEN-1:0]       slot_in_job;
  job_entry_t [LAZY_LEN-1:0] slot_entry;

  for (genvar i = 0; i < LAZY_LEN; i++) begin : g_slot
    assign slot_pos[i]    = {1'b0, i_match_head} + 5'(i);
    assign slot_in_job[i] = slot_pos[i] < 5'(JOB_LEN);
    assign slot_entry[i]  = i_entries[pos_t'(slot_pos[i])];
  end

  always_ff @(posedge clk) begin
    if (i_capture) begin
      for (int i = 0; i < LAZY_LEN; i++) begin
        o_req.head_addr[i] <= i_head_addr + addr_t'(slot_pos[i]) + addr_t'(META_HISTORY_LEN);
        o_req.strb[i]      <= slot_in_job[i] & slot_entry[i].valid & slot_entry[i].can_ext;
        o_slot_valid[i]    <= slot_in_job[i] & slot_entry[i].valid;
        // slots past the job end carry zeros
        if (slot_in_job[i]) begin
          o_req.history_addr[i] <= slot_entry[i].history_addr;
          o_slot_len[i]         <= match_len_t'(slot_entry[i].meta_len);
          o_slot_offset[i]      <= slot_entry[i].offset;
        end else begin
          o_req.history_addr[i] <= '0;
          o_slot_len[i]         <= '0;
          o_slot_offset[i]      <= '0;
        end
      end
    end else if (i_resp_fire) begin
      // extension lengths on top of the pre-matched ones
      for (int i = 0; i < LAZY_LEN; i++) begin
        if (o_req.strb[i]) begin
          o_slot_len[i] <= o_slot_len[i] + i_resp_len[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/lazy_summary.sv
// lazy summary module: best-gain candidate pick and sequence forming
`timescale 1ns/1ps
`default_nettype none

module lazy_summary #(
  parameter int JOB_LEN  = lz_job_pkg::JOB_LEN,
  parameter int LAZY_LEN = lz_job_pkg::LAZY_LEN
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        i_start,
  input  wire lz_job_pkg::pos_t                      i_match_head,
  input  wire lz_job_pkg::pos_t                      i_seq_head,
  input  wire                                        i_delim,
  input  wire [LAZY_LEN-1:0]                         i_slot_valid,
  input  wire lz_job_pkg::match_len_t [LAZY_LEN-1:0] i_slot_len,
  input  wire lz_job_pkg::offset_t [LAZY_LEN-1:0]    i_slot_offset,
  output logic                                       o_done,
  output logic                                       o_emit,
  output lz_job_pkg::seq_t                           o_seq,
  output logic [4:0]                                 o_next_head
);

  import lz_job_pkg::*;

  localparam int SEL_W = (LAZY_LEN > 1) ? $clog2(LAZY_LEN) : 1;

  logic             found;
  logic [SEL_W-1:0] best;
  logic [8:0]       gain;
  logic [8:0]       best_gain;
  ll_t              seq_ll;
  match_len_t       seq_ml;
  logic [8:0]       end_pos;
  logic             seq_eoj;

  always_comb begin
    found     = 1'b0;
    best      = '0;
    best_gain = '0;
    gain      = '0;
    for (int i = 0; i < LAZY_LEN; i++) begin
      gain = {1'b0, i_slot_len[i]} - 9'(i);
      // strict compare, so a tie keeps the earlier slot
      if (i_slot_valid[i] && (i_slot_len[i] >= match_len_t'(MIN_MATCH)) &&
          (!found || (gain > best_gain))) begin
        found     = 1'b1;
        best      = SEL_W'(i);
        best_gain = gain;
      end
    end
  end

  assign seq_ll  = ll_t'(i_match_head) - ll_t'(i_seq_head) + ll_t'(best);
  assign seq_ml  = i_slot_len[best];
  assign end_pos = 9'(i_seq_head) + 9'(seq_ll) + 9'(seq_ml);
  assign seq_eoj = end_pos >= 9'(JOB_LEN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_done <= 1'b0;
    end else begin
      o_done <= i_start;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      o_emit            <= found;
      o_seq.ll          <= seq_ll;
      o_seq.ml          <= seq_ml;
      o_seq.offset      <= i_slot_offset[best];
      o_seq.eoj         <= seq_eoj;
      // match running past the job end
      o_seq.overlap_len <= seq_eoj ? match_len_t'(end_pos - 9'(JOB_LEN)) : '0;
      o_seq.delim       <= seq_eoj & i_delim;
      o_next_head       <= end_pos[4:0];
    end
  end

endmodule

`default_nettype wire

//--- logic/job_controller.sv
// job controller module: job FSM, head pointers, match-head seek and sequence port
`timescale 1ns/1ps
`default_nettype none

module job_controller #(
  parameter int JOB_LEN     = lz_job_pkg::JOB_LEN,
  parameter int ISSUE_WIDTH = lz_job_pkg::ISSUE_WIDTH,
  parameter int LAZY_LEN    = lz_job_pkg::LAZY_LEN
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   i_beat_valid,
  output logic                  o_beat_ready,
  input  wire                   i_req_ready,
  input  wire [LAZY_LEN-1:0]    i_req_strb,
  output logic                  o_req_valid,
  input  wire                   i_resp_valid,
  output logic                  o_resp_ready,
  input  wire [JOB_LEN-1:0]     i_entry_valid,
  input  wire                   i_sum_done,
  input  wire                   i_sum_emit,
  input  wire lz_job_pkg::seq_t i_sum_seq,
  input  wire [4:0]             i_sum_next_head,
  input  wire                   i_delim,
  output logic                  o_seq_valid,
  output lz_job_pkg::seq_t      o_seq,
  input  wire                   i_seq_ready,
  output logic                  o_load,
  output logic [1:0]            o_beat_idx,
  output logic                  o_capture,
  output logic                  o_resp_fire,
  output logic                  o_start,
  output lz_job_pkg::pos_t      o_match_head,
  output lz_job_pkg::pos_t      o_seq_head
);

  import lz_job_pkg::*;

  localparam int NUM_BEATS = JOB_LEN / ISSUE_WIDTH;

  job_state_e state_q;
  job_state_e state_d;
  logic [1:0] load_cnt_q;
  pos_t       match_head_q;
  pos_t       seq_head_q;
  seq_t       seq_hold_q;
  logic       seq_pend_q;
  logic       start_q;
  logic       beat_fire;
  logic       last_beat;
  logic       seq_fire;
  logic       at_last;
  logic       skip;
  seq_t       tail_seq;

  assign beat_fire = o_beat_ready & i_beat_valid;
  assign last_beat = load_cnt_q == 2'(NUM_BEATS - 1);
  assign seq_fire  = o_seq_valid & i_seq_ready;
  assign at_last   = match_head_q == pos_t'(JOB_LEN - 1);
  assign skip      = i_sum_done & ~i_sum_emit;

  assign o_beat_ready = state_q == LOAD;
  assign o_req_valid  = (state_q == MATCH_REQ) && (|i_req_strb);
  assign o_resp_ready = state_q == MATCH_RESP;
  assign o_load       = beat_fire;
  assign o_beat_idx   = load_cnt_q;
  assign o_capture    = (state_q == SEEK) && i_entry_valid[match_head_q];
  assign o_resp_fire  = o_resp_ready & i_resp_valid;
  assign o_start      = start_q;
  assign o_match_head = match_head_q;
  assign o_seq_head   = seq_head_q;

  // literal tail covers everything from seq_head to the job end
  always_comb begin
    tail_seq       = '0;
    tail_seq.ll    = ll_t'(JOB_LEN) - ll_t'(seq_head_q);
    tail_seq.eoj   = 1'b1;
    tail_seq.delim = i_delim;
  end

  assign o_seq_valid = (state_q == LIT_TAIL) || ((state_q == SUMMARY) && seq_pend_q);
  assign o_seq       = (state_q == LIT_TAIL) ? tail_seq : seq_hold_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOAD: begin
        if (beat_fire && last_beat) begin
          state_d = SEEK;
        end
      end
      SEEK: begin
        if (i_entry_valid[match_head_q]) begin
          state_d = MATCH_REQ;
        end else if (at_last) begin
          state_d = LIT_TAIL;
        end
      end
      MATCH_REQ: begin
        if (!(|i_req_strb)) begin
          state_d = SUMMARY;
        end else if (i_req_ready) begin
          state_d = MATCH_RESP;
        end
      end
      MATCH_RESP: begin
        if (i_resp_valid) begin
          state_d = SUMMARY;
        end
      end
      SUMMARY: begin
        if (skip) begin
          state_d = at_last ? LIT_TAIL : SEEK;
        end else if (seq_fire) begin
          state_d = seq_hold_q.eoj ? LOAD : SEEK;
        end
      end
      LIT_TAIL: begin
        if (seq_fire) begin
          state_d = LOAD;
        end
      end
      default: state_d = LOAD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= LOAD;
      load_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (beat_fire) begin
        load_cnt_q <= last_beat ? 2'd0 : load_cnt_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // summary kicked off once on entry, after the window lengths settle
    start_q <= (state_d == SUMMARY) && (state_q != SUMMARY);
    if (i_sum_done) begin
      seq_hold_q <= i_sum_seq;
    end
    if ((state_q != SUMMARY) || seq_fire) begin
      seq_pend_q <= 1'b0;
    end else if (i_sum_done) begin
      seq_pend_q <= i_sum_emit;
    end
    case (state_q)
      LOAD: begin
        match_head_q <= '0;
        seq_head_q   <= '0;
      end
      SEEK: begin
        if (!i_entry_valid[match_head_q] && !at_last) begin
          if ((match_head_q < pos_t'(JOB_LEN - 8)) && !(|i_entry_valid[match_head_q +: 8])) begin
            match_head_q <= match_head_q + pos_t'(8);
          end else if ((match_head_q < pos_t'(JOB_LEN - 4)) &&
                       !(|i_entry_valid[match_head_q +: 4])) begin
            match_head_q <= match_head_q + pos_t'(4);
          end else begin
            match_head_q <= match_head_q + pos_t'(1);
          end
        end
      end
      SUMMARY: begin
        if (skip && !at_last) begin
          match_head_q <= match_head_q + pos_t'(1);
        end else if (seq_fire) begin
          match_head_q <= pos_t'(i_sum_next_head);
          seq_head_q   <= pos_t'(i_sum_next_head);
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/job_pe_top.sv
// top level of the job processing element: table, window, summary and controller
`timescale 1ns/1ps
`default_nettype none

module job_pe_top #(
  parameter int JOB_LEN     = lz_job_pkg::JOB_LEN,
  parameter int ISSUE_WIDTH = lz_job_pkg::ISSUE_WIDTH,
  parameter int LAZY_LEN    = lz_job_pkg::LAZY_LEN
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        i_beat_valid,
  input  wire lz_job_pkg::hash_beat_t                i_beat,
  output logic                                       o_beat_ready,
  output logic                                       o_req_valid,
  output lz_job_pkg::match_req_t                     o_req,
  input  wire                                        i_req_ready,
  input  wire                                        i_resp_valid,
  input  wire lz_job_pkg::match_len_t [LAZY_LEN-1:0] i_resp_len,
  output logic                                       o_resp_ready,
  output logic                                       o_seq_valid,
  output lz_job_pkg::seq_t                           o_seq,
  input  wire                                        i_seq_ready
);

  import lz_job_pkg::*;

  job_entry_t [JOB_LEN-1:0]  entries;
  logic [JOB_LEN-1:0]        entry_valid;
  addr_t                     head_addr;
  logic                      delim;
  logic                      load;
  logic [1:0]                beat_idx;
  logic                      capture;
  logic                      resp_fire;
  logic                      start;
  pos_t                      match_head;
  pos_t                      seq_head;
  logic [LAZY_LEN-1:0]       slot_valid;
  match_len_t [LAZY_LEN-1:0] slot_len;
  offset_t [LAZY_LEN-1:0]    slot_offset;
  logic                      sum_done;
  logic                      sum_emit;
  seq_t                      sum_seq;
  logic [4:0]                sum_next_head;

  for (genvar p = 0; p < JOB_LEN; p++) begin : g_valid
    assign entry_valid[p] = entries[p].valid;
  end

  job_table #(.JOB_LEN(JOB_LEN), .ISSUE_WIDTH(ISSUE_WIDTH)) u_table (
    .clk(clk), .i_load(load), .i_beat_idx(beat_idx), .i_beat(i_beat),
    .o_entries(entries), .o_head_addr(head_addr), .o_delim(delim)
  );

  lazy_window #(.JOB_LEN(JOB_LEN), .LAZY_LEN(LAZY_LEN)) u_window (
    .clk(clk), .i_capture(capture), .i_match_head(match_head), .i_entries(entries),
    .i_head_addr(head_addr), .i_resp_fire(resp_fire), .i_resp_len(i_resp_len),
    .o_req(o_req), .o_slot_valid(slot_valid), .o_slot_len(slot_len),
    .o_slot_offset(slot_offset)
  );

  lazy_summary #(.JOB_LEN(JOB_LEN), .LAZY_LEN(LAZY_LEN)) u_summary (
    .clk(clk), .rst_n(rst_n), .i_start(start), .i_match_head(match_head),
    .i_seq_head(seq_head), .i_delim(delim), .i_slot_valid(slot_valid),
    .i_slot_len(slot_len), .i_slot_offset(slot_offset), .o_done(sum_done),
    .o_emit(sum_emit), .o_seq(sum_seq), .o_next_head(sum_next_head)
  );

  job_controller #(.JOB_LEN(JOB_LEN), .ISSUE_WIDTH(ISSUE_WIDTH), .LAZY_LEN(LAZY_LEN)) u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .i_beat_valid(i_beat_valid), .o_beat_ready(o_beat_ready),
    .i_req_ready(i_req_ready), .i_req_strb(o_req.strb), .o_req_valid(o_req_valid),
    .i_resp_valid(i_resp_valid), .o_resp_ready(o_resp_ready),
    .i_entry_valid(entry_valid),
    .i_sum_done(sum_done), .i_sum_emit(sum_emit), .i_sum_seq(sum_seq),
    .i_sum_next_head(sum_next_head), .i_delim(delim),
    .o_seq_valid(o_seq_valid), .o_seq(o_seq), .i_seq_ready(i_seq_ready),
    .o_load(load), .o_beat_idx(beat_idx), .o_capture(capture),
    .o_resp_fire(resp_fire), .o_start(start),
    .o_match_head(match_head), .o_seq_head(seq_head)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release just after an edge, like the other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/job_pe_sva.sv
// handshake and reset assertions for the job controller
`timescale 1ns/1ps
`default_nettype none

module job_pe_sva #(
  parameter int LAZY_LEN = lz_job_pkg::LAZY_LEN
) (
  input wire                    clk,
  input wire                    rst_n,
  input wire                    i_beat_ready,
  input wire                    i_req_valid,
  input wire                    i_req_ready,
  input wire [LAZY_LEN-1:0]     i_req_strb,
  input wire lz_job_pkg::pos_t  i_match_head,
  input wire                    i_seq_valid,
  input wire lz_job_pkg::seq_t  i_seq,
  input wire                    i_seq_ready
);

  // request payload follows the strobes and the match head
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      i_req_valid && !i_req_ready |=>
      i_req_valid && $stable(i_req_strb) && $stable(i_match_head))
    else $error("match request dropped or changed before acceptance");

  seq_hold: assert property (@(posedge clk) disable iff (!rst_n)
      i_seq_valid && !i_seq_ready |=> i_seq_valid && $stable(i_seq))
    else $error("sequence dropped or changed before acceptance");

  beat_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
      i_beat_ready |-> !i_req_valid && !i_seq_valid)
    else $error("beat ready while a request or sequence is pending");

  reset_quiet: assert property (@(posedge clk)
      !rst_n |=> !i_req_valid && !i_seq_valid)
    else $error("valid output high right after reset");

endmodule

`default_nettype wire

//--- test/tb_job_pe.sv
// testbench top with random jobs, match responder, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_job_pe;

  import lz_job_pkg::*;

  localparam int NUM_JOBS    = 40;
  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int WATCHDOG_NS = NUM_JOBS * 400 * CLK_PERIOD;

  typedef match_len_t [LAZY_LEN-1:0] resp_lens_t;

  logic       clk;
  logic       rst_n;
  logic       i_beat_valid;
  hash_beat_t i_beat;
  logic       o_beat_ready;
  logic       o_req_valid;
  match_req_t o_req;
  logic       i_req_ready;
  logic       i_resp_valid;
  resp_lens_t i_resp_len;
  logic       o_resp_ready;
  logic       o_seq_valid;
  seq_t       o_seq;
  logic       i_seq_ready;

  logic [31:0] rng_state;
  logic        jv [JOB_LEN];
  addr_t       jh [JOB_LEN];
  meta_len_t   jm [JOB_LEN];
  logic        je [JOB_LEN];
  hash_beat_t  beat_q [$];
  match_req_t  exp_req_q [$];
  resp_lens_t  resp_q [$];
  seq_t        exp_seq_q [$];
  logic        empty_q [$];
  int          beat_ptr;
  int          resp_owed;
  int          jobs_done;
  int          job_len_sum;
  int          job_seq_cnt;
  logic        beat_fired;
  logic        resp_fired;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

  job_pe_top #(.JOB_LEN(JOB_LEN), .ISSUE_WIDTH(ISSUE_WIDTH), .LAZY_LEN(LAZY_LEN)) dut (
    .clk(clk), .rst_n(rst_n),
    .i_beat_valid(i_beat_valid), .i_beat(i_beat), .o_beat_ready(o_beat_ready),
    .o_req_valid(o_req_valid), .o_req(o_req), .i_req_ready(i_req_ready),
    .i_resp_valid(i_resp_valid), .i_resp_len(i_resp_len), .o_resp_ready(o_resp_ready),
    .o_seq_valid(o_seq_valid), .o_seq(o_seq), .i_seq_ready(i_seq_ready)
  );

  bind job_controller job_pe_sva #(.LAZY_LEN(LAZY_LEN)) u_sva (
    .clk(clk), .rst_n(rst_n), .i_beat_ready(o_beat_ready),
    .i_req_valid(o_req_valid), .i_req_ready(i_req_ready), .i_req_strb(i_req_strb),
    .i_match_head(o_match_head), .i_seq_valid(o_seq_valid), .i_seq(o_seq),
    .i_seq_ready(i_seq_ready)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_random() % 32'(n));
  endfunction

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "run stopped at the first failing check");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s expected %0h actual %0h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic add_tail_seq(input int sh, input logic delim);
    seq_t s;
    s       = '0;
    s.ll    = ll_t'(JOB_LEN - sh);
    s.eoj   = 1'b1;
    s.delim = delim;
    exp_seq_q.push_back(s);
  endtask

  // seek, window, summary and tail rules on the testbench copy of a job
  task automatic model_job(input addr_t head, input logic delim, input logic empty);
    match_req_t          req;
    resp_lens_t          rl;
    seq_t                s;
    logic [LAZY_LEN-1:0] sv;
    int                  len [LAZY_LEN];
    offset_t             off [LAZY_LEN];
    int                  mh;
    int                  sh;
    int                  pos;
    int                  best;
    int                  e;
    logic                done;
    mh   = 0;
    sh   = 0;
    done = 1'b0;
    empty_q.push_back(empty);
    while (!done) begin
      while ((mh < JOB_LEN) && !jv[mh]) begin
        mh++;
      end
      if (mh >= JOB_LEN) begin
        add_tail_seq(sh, delim);
        done = 1'b1;
      end else begin
        req = '0;
        for (int i = 0; i < LAZY_LEN; i++) begin
          pos              = mh + i;
          req.head_addr[i] = head + addr_t'(pos + META_HISTORY_LEN);
          sv[i]            = (pos < JOB_LEN) && jv[pos];
          len[i]           = 0;
          off[i]           = '0;
          if (pos < JOB_LEN) begin
            req.strb[i]         = jv[pos] && je[pos];
            req.history_addr[i] = jh[pos] + addr_t'(META_HISTORY_LEN);
            len[i]              = int'(jm[pos]);
            off[i]              = head + addr_t'(pos) - jh[pos];
          end
        end
        if (req.strb != '0) begin
          exp_req_q.push_back(req);
          for (int i = 0; i < LAZY_LEN; i++) begin
            rl[i] = match_len_t'(rand_below(16));
            if (req.strb[i]) begin
              len[i] += int'(rl[i]);
            end
          end
          resp_q.push_back(rl);
        end
        best = -1;
        for (int i = 0; i < LAZY_LEN; i++) begin
          if (sv[i] && (len[i] >= MIN_MATCH) &&
              ((best < 0) || (len[i] - i > len[best] - best))) begin
            best = i;
          end
        end
        if (best < 0) begin
          if (mh == JOB_LEN - 1) begin
            add_tail_seq(sh, delim);
            done = 1'b1;
          end else begin
            mh++;
          end
        end else begin
          e        = mh + best + len[best];
          s        = '0;
          s.ll     = ll_t'(mh - sh + best);
          s.ml     = match_len_t'(len[best]);
          s.offset = off[best];
          s.eoj    = e >= JOB_LEN;
          if (s.eoj) begin
            s.overlap_len = match_len_t'(e - JOB_LEN);
            s.delim       = delim;
            done          = 1'b1;
          end
          exp_seq_q.push_back(s);
          mh = e;
          sh = e;
        end
      end
    end
  endtask

  // every fifth job is left empty
  task automatic build_job(input int job_no);
    hash_beat_t beat;
    addr_t      head;
    logic       delim;
    logic       empty;
    int         p;
    empty = (job_no % 5) == 4;
    head  = addr_t'(next_random());
    delim = rand_below(2) == 1;
    for (p = 0; p < JOB_LEN; p++) begin
      jv[p] = !empty && (rand_below(10) < 3);
      jh[p] = addr_t'(next_random());
      jm[p] = meta_len_t'(rand_below(8));
      je[p] = rand_below(2) == 1;
    end
    for (int k = 0; k < JOB_LEN / ISSUE_WIDTH; k++) begin
      beat           = '0;
      beat.head_addr = (k == 0) ? head : addr_t'(next_random());
      beat.delim     = (k == JOB_LEN / ISSUE_WIDTH - 1) ? delim : (rand_below(2) == 1);
      for (int j = 0; j < ISSUE_WIDTH; j++) begin
        p                    = k * ISSUE_WIDTH + j;
        beat.valid[j]        = jv[p];
        beat.history_addr[j] = jh[p];
        beat.meta_len[j]     = jm[p];
        beat.can_ext[j]      = je[p];
      end
      beat_q.push_back(beat);
    end
    model_job(head, delim, empty);
  endtask

  task automatic check_request();
    match_req_t exp;
    if (exp_req_q.size() == 0) begin
      $display("match request issued when none was expected");
      stop_with_failure();
    end else begin
      exp = exp_req_q.pop_front();
      for (int i = 0; i < LAZY_LEN; i++) begin
        check_value($sformatf("request head_addr slot %0d", i),
                    32'(exp.head_addr[i]), 32'(o_req.head_addr[i]));
        check_value($sformatf("request history_addr slot %0d", i),
                    32'(exp.history_addr[i]), 32'(o_req.history_addr[i]));
      end
      check_value("request strb", 32'(exp.strb), 32'(o_req.strb));
      resp_owed++;
    end
  endtask

  task automatic check_sequence();
    seq_t exp;
    logic was_empty;
    if (exp_seq_q.size() == 0) begin
      $display("sequence output when none was expected");
      stop_with_failure();
    end else begin
      exp = exp_seq_q.pop_front();
      check_value("sequence ll", 32'(exp.ll), 32'(o_seq.ll));
      check_value("sequence ml", 32'(exp.ml), 32'(o_seq.ml));
      check_value("sequence offset", 32'(exp.offset), 32'(o_seq.offset));
      check_value("sequence eoj", 32'(exp.eoj), 32'(o_seq.eoj));
      check_value("sequence overlap_len", 32'(exp.overlap_len), 32'(o_seq.overlap_len));
      check_value("sequence delim", 32'(exp.delim), 32'(o_seq.delim));
      job_len_sum += int'(o_seq.ll) + int'(o_seq.ml);
      job_seq_cnt++;
      if (o_seq.eoj) begin
        check_value("job length sum", 32'(JOB_LEN + int'(exp.overlap_len)),
                    32'(job_len_sum));
        was_empty = empty_q.pop_front();
        if (was_empty) begin
          check_value("empty job sequence count", 32'd1, 32'(job_seq_cnt));
          check_value("empty job literal length", 32'(JOB_LEN), 32'(o_seq.ll));
        end
        jobs_done++;
        job_len_sum = 0;
        job_seq_cnt = 0;
      end
    end
  endtask

  // random stalls on every handshake the testbench drives
  task automatic drive_inputs();
    if (beat_fired) begin
      beat_ptr++;
      beat_fired   = 1'b0;
      i_beat_valid = 1'b0;
    end
    if (!i_beat_valid && (beat_ptr < beat_q.size()) && (rand_below(4) != 0)) begin
      i_beat_valid = 1'b1;
      i_beat       = beat_q[beat_ptr];
    end
    i_req_ready = rand_below(3) != 0;
    if (resp_fired) begin
      i_resp_valid = 1'b0;
      resp_fired   = 1'b0;
    end
    if (!i_resp_valid && (resp_owed > 0) && (rand_below(3) != 0)) begin
      i_resp_valid = 1'b1;
      i_resp_len   = resp_q.pop_front();
      resp_owed--;
    end
    i_seq_ready = rand_below(3) != 0;
  endtask

  // sampled mid-cycle so transfers complete on the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (i_beat_valid && o_beat_ready) begin
        beat_fired = 1'b1;
      end
      if (o_req_valid && i_req_ready) begin
        check_request();
      end
      if (o_resp_ready && i_resp_valid) begin
        resp_fired = 1'b1;
      end
      if (o_seq_valid && i_seq_ready) begin
        check_sequence();
      end
    end
  end

  initial begin
    i_beat_valid = 1'b0;
    i_beat       = '0;
    i_req_ready  = 1'b0;
    i_resp_valid = 1'b0;
    i_resp_len   = '0;
    i_seq_ready  = 1'b0;
    rng_state    = 32'd60005;
    beat_ptr     = 0;
    resp_owed    = 0;
    jobs_done    = 0;
    job_len_sum  = 0;
    job_seq_cnt  = 0;
    beat_fired   = 1'b0;
    resp_fired   = 1'b0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      build_job(j);
    end
    wait (rst_n === 1'b1);
    while (jobs_done < NUM_JOBS) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drive_inputs();
    end
    check_value("leftover requests", 32'd0, 32'(exp_req_q.size()));
    check_value("leftover responses", 32'd0, 32'(resp_q.size()));
    check_value("leftover sequences", 32'd0, 32'(exp_seq_q.size()));
    $display("All tests passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d jobs finished", jobs_done, NUM_JOBS);
    stop_with_failure();
  end

endmodule

`default_nettype wire

//--- job_pe_top.f
logic/lz_job_pkg.sv
logic/job_table.sv
logic/lazy_window.sv
logic/lazy_summary.sv
logic/job_controller.sv
logic/job_pe_top.sv
test/tb_clock_gen.sv
test/job_pe_sva.sv
test/tb_job_pe.sv

//--- run_sim.sh
#!/bin/sh
# build and run the job PE testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_job_pe -f job_pe_top.f -o sim_job_pe
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_job_pe
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi
exit 0
